/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal --timescale 1ns/1ps
TOP      = tb_top
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* design/cam_channel.sv */
`timescale 1ns/1ps

module cam_channel (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             pclk,
  input  logic                             vsync,
  input  logic                             href,
  input  logic [7:0]                       d,
  input  logic                             proc_ctrl,
  input  logic [vision_pkg::nb_addr-1:0]   disp_addr,
  output logic [vision_pkg::nb_pxl-1:0]    disp_pxl,
  output logic [vision_pkg::nb_filter-1:0] rgbfilter,
  output logic [vision_pkg::nb_col-1:0]    centroid,
  output logic [2:0]                       proximity
);
  import vision_pkg::*;

  logic               cap_we;
  logic [nb_addr-1:0] cap_addr;
  logic [nb_pxl-1:0]  cap_pxl;
  logic [nb_addr-1:0] orig_addr;
  logic [nb_pxl-1:0]  orig_pxl;
  logic               proc_we;
  logic [nb_addr-1:0] proc_addr;
  logic [nb_pxl-1:0]  proc_pxl;

  ov7670_capture u_capture (
    .clk   (clk),
    .rst_n (rst_n),
    .pclk  (pclk),
    .vsync (vsync),
    .href  (href),
    .d     (d),
    .we    (cap_we),
    .addr  (cap_addr),
    .pxl   (cap_pxl)
  );

  // camera image as captured
  frame_buffer orig_fb (
    .clk   (clk),
    .we    (cap_we),
    .waddr (cap_addr),
    .wdata (cap_pxl),
    .raddr (orig_addr),
    .rdata (orig_pxl)
  );

  color_proc u_proc (
    .clk       (clk),
    .rst_n     (rst_n),
    .proc_ctrl (proc_ctrl),
    .orig_addr (orig_addr),
    .orig_pxl  (orig_pxl),
    .proc_we   (proc_we),
    .proc_addr (proc_addr),
    .proc_pxl  (proc_pxl),
    .rgbfilter (rgbfilter),
    .centroid  (centroid),
    .proximity (proximity)
  );

  // filtered image, read by the display
  frame_buffer proc_fb (
    .clk   (clk),
    .we    (proc_we),
    .waddr (proc_addr),
    .wdata (proc_pxl),
    .raddr (disp_addr),
    .rdata (disp_pxl)
  );

endmodule

/* design/col_divider.sv */
`timescale 1ns/1ps

module col_divider (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  logic [vision_pkg::nb_sum-1:0]  dividend,
  input  logic [vision_pkg::nb_addr-1:0] divisor,
  output logic [vision_pkg::nb_col-1:0]  quotient,
  output logic                           done
);
  import vision_pkg::*;

  logic               busy;
  logic [nb_step-1:0] step;
  logic [nb_addr-1:0] rem;
  logic [nb_addr-1:0] dvsr;
  logic [nb_sum-1:0]  quo;     // dividend shifts out, quotient bits shift in
  logic [nb_addr:0]   rem_sh;
  logic [nb_addr:0]   diff;

  assign rem_sh   = {rem, quo[nb_sum-1]};
  assign diff     = rem_sh - {1'b0, dvsr};
  assign quotient = quo[nb_col-1:0];  // centroid never exceeds a column index

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy <= 1'b1;
          step <= nb_step'(nb_sum);
        end
      end else begin
        step <= step - 1'b1;
        if (step == 1) begin  // last quotient bit this cycle
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // restoring step, one bit per cycle
  always_ff @(posedge clk) begin
    if (!busy) begin
      if (start) begin
        rem  <= '0;
        quo  <= dividend;
        dvsr <= divisor;
      end
    end else if (!diff[nb_addr]) begin
      rem <= diff[nb_addr-1:0];
      quo <= {quo[nb_sum-2:0], 1'b1};
    end else begin
      rem <= rem_sh[nb_addr-1:0];
      quo <= {quo[nb_sum-2:0], 1'b0};
    end
  end

endmodule

/* design/color_proc.sv */
`timescale 1ns/1ps

module color_proc (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             proc_ctrl,
  output logic [vision_pkg::nb_addr-1:0]   orig_addr,
  input  logic [vision_pkg::nb_pxl-1:0]    orig_pxl,
  output logic                             proc_we,
  output logic [vision_pkg::nb_addr-1:0]   proc_addr,
  output logic [vision_pkg::nb_pxl-1:0]    proc_pxl,
  output logic [vision_pkg::nb_filter-1:0] rgbfilter,
  output logic [vision_pkg::nb_col-1:0]    centroid,
  output logic [2:0]                       proximity
);
  import vision_pkg::*;

  logic [2:0]         btn_s;
  logic [nb_col-1:0]  col;
  logic [nb_row-1:0]  row;
  logic               rd_last;
  logic               v1;
  logic               last_d1;
  logic               last_d2;
  logic [nb_addr-1:0] addr_d1;
  logic [nb_col-1:0]  col_d1;
  logic [nb_chan-1:0] red;
  logic [nb_chan-1:0] green;
  logic [nb_chan-1:0] blue;
  logic               match;
  logic               hit;
  logic [nb_pxl-1:0]  pxl_out;
  logic [nb_sum-1:0]  col_sum;
  logic [nb_addr-1:0] pxl_cnt;
  logic [nb_addr-1:0] cnt_hold;  // count of the sweep under division
  logic [nb_addr-1:0] prox_raw;
  logic               div_start;
  logic               div_done;
  logic [nb_col-1:0]  div_quot;

  // button sync and filter stepping
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btn_s     <= '0;
      rgbfilter <= filt_none;
    end else begin
      btn_s <= {btn_s[1:0], proc_ctrl};
      if (btn_s[1] && !btn_s[2])
        rgbfilter <= rgbfilter + 1'b1;  // none, red, green, blue, none
    end
  end

  // sweep counter, column and row kept alongside
  assign rd_last = (col == img_cols - 1) && (row == img_rows - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      orig_addr <= '0;
      col       <= '0;
      row       <= '0;
    end else if (rd_last) begin
      orig_addr <= '0;
      col       <= '0;
      row       <= '0;
    end else begin
      orig_addr <= orig_addr + 1'b1;
      if (col == img_cols - 1) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // stage 1 waits for the buffer read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1      <= 1'b0;
      last_d1 <= 1'b0;
    end else begin
      v1      <= 1'b1;
      last_d1 <= rd_last;
    end
  end

  always_ff @(posedge clk) begin
    addr_d1 <= orig_addr;
    col_d1  <= col;
  end

  assign red   = orig_pxl[nb_pxl-1 -: nb_chan];
  assign green = orig_pxl[2*nb_chan-1 -: nb_chan];
  assign blue  = orig_pxl[nb_chan-1:0];

  always_comb begin
    match   = 1'b0;
    pxl_out = '0;
    case (rgbfilter)
      filt_none: pxl_out = orig_pxl;  // pass through, nothing counted
      filt_red: begin
        match = (red >= color_hi) && (green < color_lo) && (blue < color_lo);
        if (match)
          pxl_out = {{nb_chan{1'b1}}, {(2*nb_chan){1'b0}}};
      end
      filt_green: begin
        match = (green >= color_hi) && (red < color_lo) && (blue < color_lo);
        if (match)
          pxl_out = {{nb_chan{1'b0}}, {nb_chan{1'b1}}, {nb_chan{1'b0}}};
      end
      filt_blue: begin
        match = (blue >= color_hi) && (red < color_lo) && (green < color_lo);
        if (match)
          pxl_out = {{(2*nb_chan){1'b0}}, {nb_chan{1'b1}}};
      end
      default: pxl_out = orig_pxl;
    endcase
  end

  assign hit = v1 & match;

  // stage 2, processed write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      proc_we <= 1'b0;
      last_d2 <= 1'b0;
    end else begin
      proc_we <= v1;
      last_d2 <= v1 & last_d1;  // sums are final next cycle
    end
  end

  always_ff @(posedge clk) begin
    proc_addr <= addr_d1;
    proc_pxl  <= pxl_out;
  end

  // statistics, restarted as the new sweep's first pixel lands
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_sum <= '0;
      pxl_cnt <= '0;
    end else if (last_d2) begin
      col_sum <= hit ? nb_sum'(col_d1) : '0;
      pxl_cnt <= hit ? nb_addr'(1) : '0;
    end else if (hit) begin
      col_sum <= col_sum + col_d1;
      pxl_cnt <= pxl_cnt + 1'b1;
    end
  end

  assign div_start = last_d2 && (pxl_cnt != '0);
  assign prox_raw  = cnt_hold >> prox_shift;

  col_divider u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (div_start),
    .dividend (col_sum),
    .divisor  (pxl_cnt),
    .quotient (div_quot),
    .done     (div_done)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_hold  <= '0;
      centroid  <= '0;
      proximity <= '0;
    end else begin
      if (last_d2) begin
        cnt_hold <= pxl_cnt;
        if (pxl_cnt == '0) begin  // no object, skip the divider
          centroid  <= '0;
          proximity <= '0;
        end
      end
      if (div_done) begin
        centroid  <= div_quot;
        proximity <= (prox_raw > 7) ? 3'd7 : prox_raw[2:0];
      end
    end
  end

endmodule

/* design/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
  input  logic                           clk,
  input  logic                           we,
  input  logic [vision_pkg::nb_addr-1:0] waddr,
  input  logic [vision_pkg::nb_pxl-1:0]  wdata,
  input  logic [vision_pkg::nb_addr-1:0] raddr,
  output logic [vision_pkg::nb_pxl-1:0]  rdata
);
  import vision_pkg::*;

  logic [nb_pxl-1:0] mem [img_pxls];

  // simple dual port block RAM
  always_ff @(posedge clk) begin
    if (we)
      mem[waddr] <= wdata;
    rdata <= mem[raddr];  // one cycle read latency
  end

endmodule

/* design/ov7670_capture.sv */
`timescale 1ns/1ps

module ov7670_capture (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           pclk,
  input  logic                           vsync,
  input  logic                           href,
  input  logic [7:0]                     d,
  output logic                           we,
  output logic [vision_pkg::nb_addr-1:0] addr,
  output logic [vision_pkg::nb_pxl-1:0]  pxl
);
  import vision_pkg::*;

  logic [2:0]         pclk_s;  // two sync flops plus one for the edge
  logic [1:0]         vsync_s;
  logic [1:0]         href_s;
  logic [7:0]         d_s1;
  logic [7:0]         d_s2;
  logic               pclk_rise;
  logic               take_byte;
  logic               phase;   // 0 waits for the red byte
  logic [nb_chan-1:0] red_hold;

  assign pclk_rise = pclk_s[1] & ~pclk_s[2];
  assign take_byte = pclk_rise & href_s[1];

  // camera bus into the clk domain
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pclk_s  <= '0;
      vsync_s <= '0;
      href_s  <= '0;
    end else begin
      pclk_s  <= {pclk_s[1:0], pclk};
      vsync_s <= {vsync_s[0], vsync};
      href_s  <= {href_s[0], href};
    end
  end

  // data follows the same two stages
  always_ff @(posedge clk) begin
    d_s1 <= d;
    d_s2 <= d_s1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      we    <= 1'b0;
      addr  <= '0;
      phase <= 1'b0;
    end else begin
      we <= 1'b0;
      if (we)
        addr <= addr + 1'b1;  // step past the pixel just written
      if (vsync_s[1]) begin
        addr  <= '0;
        phase <= 1'b0;
      end else if (take_byte) begin
        phase <= ~phase;
        if (phase && addr < img_pxls)
          we <= 1'b1;  // drop bytes beyond the frame
      end
    end
  end

  // byte assembly
  always_ff @(posedge clk) begin
    if (take_byte) begin
      if (!phase)
        red_hold <= d_s2[nb_chan-1:0];  // xxxx rrrr
      else
        pxl <= {red_hold, d_s2};        // gggg bbbb
    end
  end

endmodule

/* design/top_ov7670x2_centroid.sv */
`timescale 1ns/1ps

module top_ov7670x2_centroid (
  input  logic                             clk,
  input  logic                             rst_n,
  // camera 1
  input  logic                             ov7670_1_pclk,
  input  logic                             ov7670_1_vsync,
  input  logic                             ov7670_1_href,
  input  logic [7:0]                       ov7670_1_d,
  // camera 2
  input  logic                             ov7670_2_pclk,
  input  logic                             ov7670_2_vsync,
  input  logic                             ov7670_2_href,
  input  logic [7:0]                       ov7670_2_d,
  input  logic                             btnl_proc_ctrl_1,  // filter step, cam 1
  input  logic                             btnr_proc_ctrl_2,  // filter step, cam 2
  input  logic [vision_pkg::nb_addr-1:0]   disp_addr_1,
  input  logic [vision_pkg::nb_addr-1:0]   disp_addr_2,
  output logic [vision_pkg::nb_pxl-1:0]    disp_pxl_1,
  output logic [vision_pkg::nb_pxl-1:0]    disp_pxl_2,
  output logic [vision_pkg::nb_filter-1:0] rgbfilter_1,
  output logic [vision_pkg::nb_filter-1:0] rgbfilter_2,
  output logic [vision_pkg::nb_col-1:0]    centroid_1,
  output logic [vision_pkg::nb_col-1:0]    centroid_2,
  output logic [2:0]                       proximity_1,
  output logic [2:0]                       proximity_2
);

  cam_channel u_chan_1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .pclk      (ov7670_1_pclk),
    .vsync     (ov7670_1_vsync),
    .href      (ov7670_1_href),
    .d         (ov7670_1_d),
    .proc_ctrl (btnl_proc_ctrl_1),
    .disp_addr (disp_addr_1),
    .disp_pxl  (disp_pxl_1),
    .rgbfilter (rgbfilter_1),
    .centroid  (centroid_1),
    .proximity (proximity_1)
  );

  cam_channel u_chan_2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .pclk      (ov7670_2_pclk),
    .vsync     (ov7670_2_vsync),
    .href      (ov7670_2_href),
    .d         (ov7670_2_d),
    .proc_ctrl (btnr_proc_ctrl_2),
    .disp_addr (disp_addr_2),
    .disp_pxl  (disp_pxl_2),
    .rgbfilter (rgbfilter_2),
    .centroid  (centroid_2),
    .proximity (proximity_2)
  );

endmodule

/* design/vision_pkg.sv */
package vision_pkg;

  // frame geometry, QQVGA
  localparam int img_cols = 160;
  localparam int img_rows = 120;
  localparam int img_pxls = img_cols * img_rows;

  localparam int nb_addr = 15;  // 19200 words
  localparam int nb_col  = 8;
  localparam int nb_row  = 7;

  // RGB444 pixel, red on top
  localparam int nb_chan = 4;
  localparam int nb_pxl  = 3 * nb_chan;

  localparam int nb_sum  = 22;  // 159 * 19200 fits
  localparam int nb_step = 5;   // divider step counter, counts nb_sum down to 1

  // color filter codes
  localparam int nb_filter = 2;
  localparam logic [nb_filter-1:0] filt_none  = 2'd0;
  localparam logic [nb_filter-1:0] filt_red   = 2'd1;
  localparam logic [nb_filter-1:0] filt_green = 2'd2;
  localparam logic [nb_filter-1:0] filt_blue  = 2'd3;

  // match thresholds on a 4-bit channel
  localparam logic [nb_chan-1:0] color_hi = 4'd8;  // selected channel at least this
  localparam logic [nb_chan-1:0] color_lo = 4'd4;  // others strictly below

  localparam int prox_shift = 9;  // 512 pixels per proximity step

endpackage

/* files.f */
design/vision_pkg.sv
design/ov7670_capture.sv
design/frame_buffer.sv
design/col_divider.sv
design/color_proc.sv
design/cam_channel.sv
design/top_ov7670x2_centroid.sv
test/tb_top.sv

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
  import vision_pkg::*;

  localparam int frame_cycles  = 16 + img_rows * (img_cols * 8 + 16);
  localparam int settle_cycles = 2 * img_pxls + 40;
  // four frames, settles and full reads, with a wide margin
  localparam int limit_cycles  = 8 * frame_cycles + 16 * settle_cycles;

  logic                 clk;
  logic                 rst_n;
  logic                 cam_pclk [1:2];
  logic                 cam_vsync [1:2];
  logic                 cam_href [1:2];
  logic [7:0]           cam_d [1:2];
  logic                 btn [1:2];
  logic [nb_addr-1:0]   disp_addr_1;
  logic [nb_addr-1:0]   disp_addr_2;
  logic [nb_pxl-1:0]    disp_pxl_1;
  logic [nb_pxl-1:0]    disp_pxl_2;
  logic [nb_filter-1:0] rgbfilter_1;
  logic [nb_filter-1:0] rgbfilter_2;
  logic [nb_col-1:0]    centroid_1;
  logic [nb_col-1:0]    centroid_2;
  logic [2:0]           proximity_1;
  logic [2:0]           proximity_2;

  logic [nb_pxl-1:0]    img [1:2][img_pxls];  // frames as sent
  logic [nb_filter-1:0] filt_exp [1:2];       // filter each button should have selected
  int                   errors;
  int                   test_err;
  int                   tests;
  int                   failed;
  int                   cycle_cnt = 0;
  int unsigned          seed_ret;

  top_ov7670x2_centroid u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .ov7670_1_pclk    (cam_pclk[1]),
    .ov7670_1_vsync   (cam_vsync[1]),
    .ov7670_1_href    (cam_href[1]),
    .ov7670_1_d       (cam_d[1]),
    .ov7670_2_pclk    (cam_pclk[2]),
    .ov7670_2_vsync   (cam_vsync[2]),
    .ov7670_2_href    (cam_href[2]),
    .ov7670_2_d       (cam_d[2]),
    .btnl_proc_ctrl_1 (btn[1]),
    .btnr_proc_ctrl_2 (btn[2]),
    .disp_addr_1      (disp_addr_1),
    .disp_addr_2      (disp_addr_2),
    .disp_pxl_1       (disp_pxl_1),
    .disp_pxl_2       (disp_pxl_2),
    .rgbfilter_1      (rgbfilter_1),
    .rgbfilter_2      (rgbfilter_2),
    .centroid_1       (centroid_1),
    .centroid_2       (centroid_2),
    .proximity_1      (proximity_1),
    .proximity_2      (proximity_2)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == limit_cycles) begin
      $display("timeout: run did not finish within %0d cycles", limit_cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // processed pixel from the match rule
  function automatic logic [nb_pxl-1:0] exp_pxl(logic [nb_filter-1:0] filt,
                                                logic [nb_pxl-1:0] p);
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    r = p[11:8];
    g = p[7:4];
    b = p[3:0];
    case (filt)
      filt_red:   return (r >= color_hi && g < color_lo && b < color_lo) ? 12'hf00 : 12'h000;
      filt_green: return (g >= color_hi && r < color_lo && b < color_lo) ? 12'h0f0 : 12'h000;
      filt_blue:  return (b >= color_hi && r < color_lo && g < color_lo) ? 12'h00f : 12'h000;
      default:    return p;
    endcase
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(string name);
    tests++;
    if (errors == test_err) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d errors", name, errors - test_err);
    end
    test_err = errors;
  endtask

  task automatic fill_rect(int cam, logic [11:0] bg, logic [11:0] obj,
                           int c0, int c1, int r0, int r1);
    int col;
    int row;
    for (int i = 0; i < img_pxls; i++) begin
      col = i % img_cols;
      row = i / img_cols;
      img[cam][i] = (col >= c0 && col <= c1 && row >= r0 && row <= r1) ? obj : bg;
    end
  endtask

  task automatic fill_random(int cam, bit red_seven);
    logic [nb_pxl-1:0] p;
    for (int i = 0; i < img_pxls; i++) begin
      p = nb_pxl'($urandom);
      if (red_seven)
        p[11:8] = 4'd7;
      img[cam][i] = p;
    end
  endtask

  // one byte per pclk period of 4 clk cycles
  task automatic send_byte(int cam, logic [7:0] b);
    cam_d[cam]    = b;
    cam_pclk[cam] = 1'b0;
    repeat (2) @(negedge clk);
    cam_pclk[cam] = 1'b1;
    repeat (2) @(negedge clk);
  endtask

  task automatic send_frame(int cam);
    logic [nb_pxl-1:0] p;
    cam_vsync[cam] = 1'b1;
    repeat (8) @(negedge clk);
    cam_vsync[cam] = 1'b0;
    repeat (8) @(negedge clk);
    for (int row = 0; row < img_rows; row++) begin
      cam_href[cam] = 1'b1;
      for (int col = 0; col < img_cols; col++) begin
        p = img[cam][row * img_cols + col];
        send_byte(cam, {4'h0, p[11:8]});  // red in the low nibble
        send_byte(cam, p[7:0]);
      end
      cam_href[cam] = 1'b0;
      cam_pclk[cam] = 1'b0;
      repeat (16) @(negedge clk);  // line blanking
    end
  endtask

  task automatic press(int cam);
    btn[cam] = 1'b1;
    repeat (4) @(negedge clk);
    btn[cam] = 1'b0;
    repeat (4) @(negedge clk);
    filt_exp[cam] = filt_exp[cam] + 2'd1;  // none, red, green, blue, none
  endtask

  task automatic set_filter(int cam, logic [nb_filter-1:0] target);
    while (filt_exp[cam] != target)
      press(cam);
    check_val($sformatf("rgbfilter_%0d", cam), (cam == 1) ? rgbfilter_1 : rgbfilter_2, target);
  endtask

  task automatic settle();
    repeat (settle_cycles) @(negedge clk);
  endtask

  task automatic check_pixel(int cam, int a);
    logic [nb_pxl-1:0] got;
    logic [nb_pxl-1:0] exp;
    exp = exp_pxl(filt_exp[cam], img[cam][a]);
    if (cam == 1)
      disp_addr_1 = nb_addr'(a);
    else
      disp_addr_2 = nb_addr'(a);
    @(negedge clk);  // registered read
    got = (cam == 1) ? disp_pxl_1 : disp_pxl_2;
    check_val($sformatf("disp_pxl_%0d at address %0d", cam, a), got, exp);
  endtask

  task automatic check_frame(int cam);
    int err_start;
    err_start = errors;
    for (int a = 0; a < img_pxls && errors - err_start < 5; a++)
      check_pixel(cam, a);
    if (errors - err_start >= 5)
      $display("frame read of camera %0d stopped after 5 mismatches", cam);
  endtask

  task automatic calc_stats(int cam, output int cent, output int prox);
    int sum;
    int cnt;
    sum = 0;
    cnt = 0;
    for (int i = 0; i < img_pxls; i++) begin
      if (filt_exp[cam] != filt_none && exp_pxl(filt_exp[cam], img[cam][i]) != '0) begin
        sum += i % img_cols;
        cnt++;
      end
    end
    cent = (cnt != 0) ? sum / cnt : 0;
    prox = ((cnt >> prox_shift) > 7) ? 7 : (cnt >> prox_shift);
  endtask

  task automatic check_stats(int cam, int cent, int prox);
    check_val($sformatf("centroid_%0d", cam), (cam == 1) ? centroid_1 : centroid_2, cent);
    check_val($sformatf("proximity_%0d", cam), (cam == 1) ? proximity_1 : proximity_2, prox);
  endtask

  task automatic test_reset();
    check_val("rgbfilter_1", rgbfilter_1, 0);
    check_val("rgbfilter_2", rgbfilter_2, 0);
    check_stats(1, 0, 0);
    check_stats(2, 0, 0);
    finish_test("reset values");
  endtask

  task automatic test_passthrough();
    int a;
    fill_random(1, 1'b0);
    fill_random(2, 1'b0);
    fork
      send_frame(1);
      send_frame(2);
    join
    settle();
    repeat (200) begin
      a = $urandom % img_pxls;
      check_pixel(1, a);
      a = $urandom % img_pxls;
      check_pixel(2, a);
    end
    check_stats(1, 0, 0);
    check_stats(2, 0, 0);
    finish_test("pass-through");
  endtask

  task automatic test_filter_step();
    press(1);
    check_val("rgbfilter_1", rgbfilter_1, filt_red);
    check_val("rgbfilter_2", rgbfilter_2, filt_none);
    repeat (3) press(1);
    check_val("rgbfilter_1", rgbfilter_1, filt_none);
    finish_test("filter stepping");
  endtask

  task automatic test_red_object();
    set_filter(1, filt_red);
    fill_rect(1, 12'h888, 12'hf00, 100, 109, 0, 59);
    send_frame(1);
    settle();
    check_stats(1, 104, 1);  // 600 pixels, mean column 104.5
    check_frame(1);
    finish_test("red object");
  endtask

  task automatic test_two_cams();
    int c1;
    int p1;
    int c2;
    int p2;
    set_filter(1, filt_blue);
    set_filter(2, filt_green);
    fill_rect(1, 12'h888, 12'h00f, 10, 29, 20, 99);
    fill_rect(2, 12'h888, 12'h383, 140, 159, 0, img_rows - 1);  // green just at the limits
    fork
      send_frame(1);
      send_frame(2);
    join
    settle();
    calc_stats(1, c1, p1);
    calc_stats(2, c2, p2);
    check_stats(1, c1, p1);
    check_stats(2, c2, p2);
    check_frame(1);
    check_frame(2);
    finish_test("two cameras");
  endtask

  task automatic test_no_match();
    set_filter(1, filt_red);
    fill_random(1, 1'b1);
    send_frame(1);
    settle();
    check_stats(1, 0, 0);
    check_frame(1);
    finish_test("no match");
  endtask

  initial begin
    seed_ret = $urandom(45);
    rst_n    = 1'b0;
    for (int c = 1; c <= 2; c++) begin
      cam_pclk[c]  = 1'b0;
      cam_vsync[c] = 1'b0;
      cam_href[c]  = 1'b0;
      cam_d[c]     = 8'h00;
      btn[c]       = 1'b0;
      filt_exp[c]  = filt_none;
    end
    disp_addr_1 = '0;
    disp_addr_2 = '0;
    errors      = 0;
    test_err    = 0;
    tests       = 0;
    failed      = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset();
    test_passthrough();
    test_filter_step();
    test_red_object();
    test_two_cams();
    test_no_match();

    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
